// ==== source/dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// associativity
`define DCACHE_WAYS 2

// sets per way
`define DCACHE_SETS 128

// words per line and beats per burst
`define DCACHE_LINE_WORDS 16

// byte address and word widths
`define DCACHE_ADDR_WIDTH 32
`define DCACHE_DATA_WIDTH 32

`endif

// ==== source/bus_pkg.sv ====
`include "dcache_defines.svh"

package bus_pkg;

    // one data word on the cpu or memory side
    typedef logic [`DCACHE_DATA_WIDTH-1:0] word_t;

    // one enable per byte lane
    typedef logic [`DCACHE_DATA_WIDTH/8-1:0] strobe_t;

    typedef logic [`DCACHE_ADDR_WIDTH-1:0] byte_addr_t;

    // beat position inside a line burst
    typedef logic [$clog2(`DCACHE_LINE_WORDS)-1:0] beat_t;

endpackage

// ==== source/dcache_pkg.sv ====
`include "dcache_defines.svh"

package dcache_pkg;

    // field widths of a byte address
    localparam int BYTE_BITS = $clog2(`DCACHE_DATA_WIDTH / 8);
    localparam int OFFSET_BITS = $clog2(`DCACHE_LINE_WORDS);
    localparam int INDEX_BITS = $clog2(`DCACHE_SETS);
    localparam int WAY_BITS = $clog2(`DCACHE_WAYS);
    localparam int TAG_BITS = `DCACHE_ADDR_WIDTH - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

    typedef logic [TAG_BITS-1:0] tag_t;

    typedef logic [INDEX_BITS-1:0] index_t;

    // word within a line
    typedef logic [OFFSET_BITS-1:0] offset_t;

    typedef logic [WAY_BITS-1:0] way_t;

    // data ram word address made of way, set and word
    typedef logic [WAY_BITS+INDEX_BITS+OFFSET_BITS-1:0] ram_addr_t;

endpackage

// ==== source/tag_store.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module tag_store
    import bus_pkg::*;
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,

    input  byte_addr_t lookup_addr,

    output logic       hit,
    output way_t       hit_way,
    output way_t       victim_way,
    output logic       victim_dirty,
    output tag_t       victim_tag,

    input  logic       touch,
    input  logic       touch_write,
    input  logic       fill_done
);
    tag_t tag_mem [`DCACHE_WAYS][`DCACHE_SETS];

    logic [`DCACHE_WAYS-1:0][`DCACHE_SETS-1:0] valid_bits;
    logic [`DCACHE_WAYS-1:0][`DCACHE_SETS-1:0] dirty_bits;

    // per set, the way to replace next
    logic [`DCACHE_SETS-1:0][WAY_BITS-1:0] lru_bits;

    tag_t                    lookup_tag;
    index_t                  lookup_index;
    logic [`DCACHE_WAYS-1:0] way_hit;

    assign lookup_tag = lookup_addr[`DCACHE_ADDR_WIDTH-1 -: TAG_BITS];
    assign lookup_index = lookup_addr[BYTE_BITS+OFFSET_BITS +: INDEX_BITS];

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_cmp
        assign way_hit[w] = valid_bits[w][lookup_index]
                            && (tag_mem[w][lookup_index] == lookup_tag);
    end

    assign hit = |way_hit;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // the victim holds during a miss since lru only moves on touch or fill
    assign victim_way = lru_bits[lookup_index];
    assign victim_tag = tag_mem[victim_way][lookup_index];
    assign victim_dirty = valid_bits[victim_way][lookup_index]
                          & dirty_bits[victim_way][lookup_index];

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_mem[victim_way][lookup_index] <= lookup_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            lru_bits <= '0;
        end else if (fill_done) begin
            valid_bits[victim_way][lookup_index] <= 1'b1;
            dirty_bits[victim_way][lookup_index] <= 1'b0;
            lru_bits[lookup_index] <= ~victim_way;
        end else if (touch) begin
            if (touch_write) begin
                dirty_bits[hit_way][lookup_index] <= 1'b1;
            end
            lru_bits[lookup_index] <= ~hit_way;
        end
    end

endmodule

// ==== source/line_ram.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module line_ram
    import bus_pkg::*;
    import dcache_pkg::*;
(
    input  logic      clk,

    input  logic      a_en,
    input  ram_addr_t a_addr,
    input  strobe_t   a_strobe,
    input  word_t     a_wdata,
    output word_t     a_rdata,

    input  logic      b_en,
    input  ram_addr_t b_addr,
    input  strobe_t   b_strobe,
    input  word_t     b_wdata,
    output word_t     b_rdata
);
    localparam int DEPTH = `DCACHE_WAYS * `DCACHE_SETS * `DCACHE_LINE_WORDS;
    localparam int LANES = `DCACHE_DATA_WIDTH / 8;

    word_t mem [DEPTH];

    // reads return the word as it was before this edge
    always_ff @(posedge clk) begin
        if (a_en) begin
            a_rdata <= mem[a_addr];
            for (int i = 0; i < LANES; i++) begin
                if (a_strobe[i]) begin
                    mem[a_addr][8*i +: 8] <= a_wdata[8*i +: 8];
                end
            end
        end
        if (b_en) begin
            b_rdata <= mem[b_addr];
            for (int i = 0; i < LANES; i++) begin
                if (b_strobe[i]) begin
                    mem[b_addr][8*i +: 8] <= b_wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// ==== source/miss_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module miss_ctrl
    import bus_pkg::*;
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,

    input  logic       req_valid,
    input  byte_addr_t req_addr,
    input  strobe_t    req_wstrobe,
    input  word_t      req_wdata,
    output logic       req_ready,
    output logic       rsp_valid,
    output word_t      rsp_rdata,

    input  logic       hit,
    input  way_t       hit_way,
    input  way_t       victim_way,
    input  logic       victim_dirty,
    input  tag_t       victim_tag,
    output logic       touch,
    output logic       touch_write,
    output logic       fill_done,

    output logic       a_en,
    output ram_addr_t  a_addr,
    output strobe_t    a_strobe,
    output word_t      a_wdata,
    input  word_t      a_rdata,
    output logic       b_en,
    output ram_addr_t  b_addr,
    output strobe_t    b_strobe,
    output word_t      b_wdata,
    input  word_t      b_rdata,

    output logic       mem_valid,
    output logic       mem_write,
    output byte_addr_t mem_addr,
    output word_t      mem_wdata,
    input  logic       mem_ready,
    input  word_t      mem_rdata,
    input  logic       mem_last
);
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_BUFFER,
        ST_WRITEBACK,
        ST_REFILL,
        ST_INSTALL
    } state_t;

    state_t state;
    beat_t  beat;

    // counts sixteen reads plus one cycle for the last read data
    logic [OFFSET_BITS:0] buf_cnt;

    word_t  line_buf [`DCACHE_LINE_WORDS];
    way_t   miss_way;
    tag_t   wb_tag;

    tag_t    req_tag;
    index_t  req_index;
    offset_t req_offset;
    logic    miss_start;
    logic    beat_fire;

    assign req_tag = req_addr[`DCACHE_ADDR_WIDTH-1 -: TAG_BITS];
    assign req_index = req_addr[BYTE_BITS+OFFSET_BITS +: INDEX_BITS];
    assign req_offset = req_addr[BYTE_BITS +: OFFSET_BITS];

    assign req_ready = (state == ST_IDLE) && hit;
    assign touch = req_valid && req_ready;
    assign touch_write = |req_wstrobe;
    assign fill_done = (state == ST_INSTALL);
    assign miss_start = (state == ST_IDLE) && req_valid && !hit;

    // cpu hits go through port a
    assign a_en = touch;
    assign a_addr = {hit_way, req_index, req_offset};
    assign a_strobe = req_wstrobe;
    assign a_wdata = req_wdata;
    assign rsp_rdata = a_rdata;

    assign mem_valid = (state == ST_WRITEBACK) || (state == ST_REFILL);
    assign mem_write = (state == ST_WRITEBACK);
    assign mem_addr = {(mem_write ? wb_tag : req_tag), req_index,
                       {(OFFSET_BITS + BYTE_BITS){1'b0}}};
    assign mem_wdata = line_buf[beat];
    assign beat_fire = mem_valid && mem_ready;

    // port b serves victim reads, then refill writes
    always_comb begin
        b_en = 1'b0;
        b_addr = {miss_way, req_index, offset_t'(buf_cnt)};
        b_strobe = '0;
        b_wdata = mem_rdata;
        if (state == ST_BUFFER) begin
            b_en = !buf_cnt[OFFSET_BITS];
        end else if (state == ST_REFILL) begin
            b_en = beat_fire;
            b_strobe = '1;
            b_addr = {miss_way, req_index, offset_t'(beat)};
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= ST_IDLE;
            beat <= '0;
            buf_cnt <= '0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= touch;
            case (state)
                ST_IDLE: begin
                    if (miss_start) begin
                        beat <= '0;
                        buf_cnt <= '0;
                        state <= victim_dirty ? ST_BUFFER : ST_REFILL;
                    end
                end
                ST_BUFFER: begin
                    buf_cnt <= buf_cnt + 1'b1;
                    if (buf_cnt[OFFSET_BITS]) begin
                        state <= ST_WRITEBACK;
                    end
                end
                ST_WRITEBACK: begin
                    if (beat_fire) begin
                        beat <= mem_last ? '0 : beat + 1'b1;
                        if (mem_last) begin
                            state <= ST_REFILL;
                        end
                    end
                end
                ST_REFILL: begin
                    if (beat_fire) begin
                        beat <= mem_last ? '0 : beat + 1'b1;
                        if (mem_last) begin
                            state <= ST_INSTALL;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // victim line copy trails the port b address by one read
    always_ff @(posedge clk) begin
        if (miss_start) begin
            miss_way <= victim_way;
            wb_tag <= victim_tag;
        end
        if ((state == ST_BUFFER) && (buf_cnt != '0)) begin
            line_buf[offset_t'(buf_cnt - 1'b1)] <= b_rdata;
        end
    end

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top
    import bus_pkg::*;
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,

    input  logic       req_valid,
    input  byte_addr_t req_addr,
    input  strobe_t    req_wstrobe,
    input  word_t      req_wdata,
    output logic       req_ready,
    output logic       rsp_valid,
    output word_t      rsp_rdata,

    output logic       mem_valid,
    output logic       mem_write,
    output byte_addr_t mem_addr,
    output word_t      mem_wdata,
    input  logic       mem_ready,
    input  word_t      mem_rdata,
    input  logic       mem_last
);
    logic      hit;
    way_t      hit_way;
    way_t      victim_way;
    logic      victim_dirty;
    tag_t      victim_tag;
    logic      touch;
    logic      touch_write;
    logic      fill_done;

    logic      a_en;
    ram_addr_t a_addr;
    strobe_t   a_strobe;
    word_t     a_wdata;
    word_t     a_rdata;
    logic      b_en;
    ram_addr_t b_addr;
    strobe_t   b_strobe;
    word_t     b_wdata;
    word_t     b_rdata;

    tag_store u_tag_store (
        .clk, .resetn,
        .lookup_addr(req_addr),
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .touch, .touch_write, .fill_done
    );

    line_ram u_line_ram (
        .clk,
        .a_en, .a_addr, .a_strobe, .a_wdata, .a_rdata,
        .b_en, .b_addr, .b_strobe, .b_wdata, .b_rdata
    );

    miss_ctrl u_miss_ctrl (
        .clk, .resetn,
        .req_valid, .req_addr, .req_wstrobe, .req_wdata,
        .req_ready, .rsp_valid, .rsp_rdata,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .touch, .touch_write, .fill_done,
        .a_en, .a_addr, .a_strobe, .a_wdata, .a_rdata,
        .b_en, .b_addr, .b_strobe, .b_wdata, .b_rdata,
        .mem_valid, .mem_write, .mem_addr, .mem_wdata,
        .mem_ready, .mem_rdata, .mem_last
    );

endmodule

// ==== tb/mem_model.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module mem_model
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       mem_valid,
    input  logic       mem_write,
    input  byte_addr_t mem_addr,
    input  word_t      mem_wdata,
    output logic       mem_ready,
    output word_t      mem_rdata,
    output logic       mem_last,
    output int         refill_count,
    output int         writeback_count
);
    localparam word_t FILL_KEY = 32'hc3a50000;

    // only words written by the cache are stored
    word_t      store [byte_addr_t];
    beat_t      beat;
    int         stall;
    byte_addr_t beat_addr;

    function automatic word_t read_word(input byte_addr_t addr);
        if (store.exists(addr)) begin
            return store[addr];
        end
        return addr ^ FILL_KEY;
    endfunction

    // a beat presented with ready high always transfers at the next rising edge
    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        mem_last = 1'b0;
        refill_count = 0;
        writeback_count = 0;
        beat = '0;
        stall = 0;
        @(posedge clk);
        stall = $urandom % 3;
        forever begin
            @(negedge clk);
            mem_ready = 1'b0;
            mem_last = 1'b0;
            if (mem_valid) begin
                if (stall > 0) begin
                    stall = stall - 1;
                end else begin
                    beat_addr = mem_addr + byte_addr_t'({beat, 2'b00});
                    if (mem_write) begin
                        store[beat_addr] = mem_wdata;
                    end else begin
                        mem_rdata = read_word(beat_addr);
                    end
                    mem_ready = 1'b1;
                    mem_last = (beat == beat_t'(`DCACHE_LINE_WORDS - 1));
                    if (mem_last && mem_write) begin
                        writeback_count = writeback_count + 1;
                    end else if (mem_last) begin
                        refill_count = refill_count + 1;
                    end
                    // wraps to zero after the last beat
                    beat = beat + 1'b1;
                    stall = $urandom % 3;
                end
            end
        end
    end

endmodule

// ==== tb/dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tb
    import bus_pkg::*;
();
    localparam int SEED = 79538;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam word_t FILL_KEY = 32'hc3a50000;
    localparam int INDEX_SHIFT = 2 + $clog2(`DCACHE_LINE_WORDS);
    localparam int TAG_SHIFT = INDEX_SHIFT + $clog2(`DCACHE_SETS);

    logic       clk;
    logic       resetn;
    logic       req_valid;
    byte_addr_t req_addr;
    strobe_t    req_wstrobe;
    word_t      req_wdata;
    logic       req_ready;
    logic       rsp_valid;
    word_t      rsp_rdata;
    logic       mem_valid;
    logic       mem_write;
    byte_addr_t mem_addr;
    word_t      mem_wdata;
    logic       mem_ready;
    word_t      mem_rdata;
    logic       mem_last;
    int         refill_count;
    int         writeback_count;
    int         cycle_count = 0;
    int         refill_mark;
    int         writeback_mark;

    // expected memory contents under the fill rule of the model
    word_t ref_mem [byte_addr_t];

    dcache_top UUT (
        .clk, .resetn,
        .req_valid, .req_addr, .req_wstrobe, .req_wdata,
        .req_ready, .rsp_valid, .rsp_rdata,
        .mem_valid, .mem_write, .mem_addr, .mem_wdata,
        .mem_ready, .mem_rdata, .mem_last
    );

    mem_model u_mem (
        .clk,
        .mem_valid, .mem_write, .mem_addr, .mem_wdata,
        .mem_ready, .mem_rdata, .mem_last,
        .refill_count, .writeback_count
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error %s got %h expected %h", name, got, expected);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic byte_addr_t make_addr(input int tag, input int index, input int offset);
        return byte_addr_t'((tag << TAG_SHIFT) | (index << INDEX_SHIFT) | (offset << 2));
    endfunction

    function automatic word_t ref_read(input byte_addr_t addr);
        if (ref_mem.exists(addr)) begin
            return ref_mem[addr];
        end
        return addr ^ FILL_KEY;
    endfunction

    function automatic void ref_write(input byte_addr_t addr, input strobe_t strobe,
                                      input word_t data);
        word_t w;
        w = ref_read(addr);
        for (int i = 0; i < 4; i++) begin
            if (strobe[i]) begin
                w[8*i +: 8] = data[8*i +: 8];
            end
        end
        ref_mem[addr] = w;
    endfunction

    // one request from a falling edge to the falling edge after its transfer
    task automatic access(input byte_addr_t addr, input strobe_t strobe, input word_t wdata,
                          output word_t rdata);
        req_addr = addr;
        req_wstrobe = strobe;
        req_wdata = wdata;
        @(negedge clk);
        check_value("rsp_valid", 32'(rsp_valid), 32'h0);
        while (!req_ready) begin
            req_valid = 1'b1;
            @(negedge clk);
            check_value("rsp_valid", 32'(rsp_valid), 32'h0);
        end
        // the transfer happens at the next rising edge while ready holds
        req_valid = 1'b1;
        @(negedge clk);
        req_valid = 1'b0;
        check_value("rsp_valid", 32'(rsp_valid), 32'h1);
        rdata = rsp_rdata;
    endtask

    task automatic read_check(input byte_addr_t addr);
        word_t r;
        access(addr, 4'h0, 32'h0, r);
        check_value("rsp_rdata", r, ref_read(addr));
    endtask

    task automatic write_word(input byte_addr_t addr, input strobe_t strobe, input word_t data);
        word_t r;
        access(addr, strobe, data, r);
        ref_write(addr, strobe, data);
    endtask

    task automatic mark_bursts();
        refill_mark = refill_count;
        writeback_mark = writeback_count;
    endtask

    task automatic expect_bursts(input int refills, input int writebacks);
        check_value("refill_count", refill_count - refill_mark, refills);
        check_value("writeback_count", writeback_count - writeback_mark, writebacks);
    endtask

    task automatic read_after_reset();
        mark_bursts();
        read_check(make_addr(5, 3, 7));
        expect_bursts(1, 0);
    endtask

    task automatic byte_strobe_merge();
        mark_bursts();
        write_word(make_addr(5, 3, 7), 4'b0101, 32'h11223344);
        read_check(make_addr(5, 3, 7));
        expect_bursts(0, 0);
    endtask

    task automatic lru_replacement();
        read_check(make_addr(1, 10, 0));
        read_check(make_addr(2, 10, 1));
        mark_bursts();
        read_check(make_addr(1, 10, 2));
        expect_bursts(0, 0);
        // b is now least recent and goes
        read_check(make_addr(3, 10, 3));
        expect_bursts(1, 0);
        mark_bursts();
        read_check(make_addr(1, 10, 4));
        expect_bursts(0, 0);
        read_check(make_addr(2, 10, 5));
        expect_bursts(1, 0);
    endtask

    task automatic dirty_writeback();
        byte_addr_t a;
        a = make_addr(4, 20, 9);
        mark_bursts();
        write_word(a, 4'hf, 32'hdeadbeef);
        read_check(make_addr(5, 20, 0));
        read_check(make_addr(6, 20, 0));
        expect_bursts(3, 1);
        check_value("mem_word", u_mem.read_word(a), ref_read(a));
        read_check(a);
        expect_bursts(4, 1);
    endtask

    task automatic clean_eviction();
        mark_bursts();
        for (int t = 7; t < 11; t++) begin
            read_check(make_addr(t, 30, t));
        end
        expect_bursts(4, 0);
    endtask

    task automatic random_mix();
        byte_addr_t addr;
        strobe_t    strobe;
        for (int n = 0; n < 200; n++) begin
            addr = make_addr(100 + int'($urandom % 8), 40 + int'($urandom % 4),
                             int'($urandom % 16));
            if ($urandom % 2 == 1) begin
                strobe = strobe_t'($urandom % 15 + 1);
                write_word(addr, strobe, $urandom);
            end else begin
                read_check(addr);
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        resetn = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_wstrobe = '0;
        req_wdata = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        resetn = 1'b0;
        check_value("req_ready", 32'(req_ready), 32'h0);
        check_value("mem_valid", 32'(mem_valid), 32'h0);
        read_after_reset();
        byte_strobe_merge();
        lru_replacement();
        dirty_writeback();
        clean_eviction();
        random_mix();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+source
source/bus_pkg.sv
source/dcache_pkg.sv
source/tag_store.sv
source/line_ram.sv
source/miss_ctrl.sv
source/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

// ==== Makefile ====
# Verilator build and run for the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
SEED      ?= 79538
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(wildcard source/*.sv source/*.svh tb/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

# rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) filelist.f
	$(VERILATOR) $(VFLAGS) -f filelist.f --top-module $(TOP) --Mdir $(OBJ_DIR)

# exit status of the binary is the test result
run: $(BINARY)
	./$(BINARY) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJ_DIR)
